// ==== build.f ====
common/gsu_map_pkg.sv
common/gsu_bus_pkg.sv
mmio/mmio_decode.sv
mmio/gsu_regs.sv
mmio/gsu_cache.sv
design/gsu.sv
verification/gsu_checker.sv
verification/gsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the GSU host interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module gsu_tb \
  -Mdir obj_dir -o gsu_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/gsu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "All checks passed" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== verification/gsu_tb.sv ====
`timescale 1ns/1ns
module gsu_tb;

  localparam logic [7:0] VERSION = 8'd4;
  localparam int NUM_TESTS = 6;
  // Cache test is longest, about 1030 accesses of up to 8 cycles
  localparam int MAX_TEST_CYCLES = 9000;
  localparam int TIMEOUT_NS = 2 * NUM_TESTS * MAX_TEST_CYCLES * 100;

  logic        CLK = 1'b0;
  logic        RST;
  logic        ENABLE;
  logic        SNES_RD_start;
  logic        SNES_WR_end;
  logic [9:0]  SNES_ADDR;
  logic [7:0]  DATA_IN;
  logic        DATA_ENABLE;
  logic [7:0]  DATA_OUT;

  // Stimulus source and expected state
  logic [31:0] lfsr = 32'h7442;
  logic [15:0] exp_gpr [16];
  logic [7:0]  exp_cache [512];
  string       test_name;
  int          test_errs;
  int          tests_passed = 0;
  int          tests_failed = 0;

  gsu #(.VERSION(VERSION)) DUT (
    .CLK           (CLK),
    .RST           (RST),
    .ENABLE        (ENABLE),
    .SNES_RD_start (SNES_RD_start),
    .SNES_WR_end   (SNES_WR_end),
    .SNES_ADDR     (SNES_ADDR),
    .DATA_IN       (DATA_IN),
    .DATA_ENABLE   (DATA_ENABLE),
    .DATA_OUT      (DATA_OUT)
  );

  bind gsu gsu_checker chk (
    .CLK           (CLK),
    .RST           (RST),
    .ENABLE        (ENABLE),
    .SNES_RD_start (SNES_RD_start),
    .SNES_WR_end   (SNES_WR_end),
    .DATA_ENABLE   (DATA_ENABLE)
  );

  // 100 ns period
  always #50 CLK = ~CLK;

  // Galois LFSR, one step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[14:0], lfsr[0]};
    end
    return r;
  endfunction

  // ----------------------------------------
  // Host bus tasks
  // ----------------------------------------
  // One-cycle write strobe, then idle to keep spacing
  task automatic host_write(input logic [9:0] addr, input logic [7:0] data, input logic en);
    @(posedge CLK);
    ENABLE <= en;
    SNES_WR_end <= 1'b1;
    SNES_ADDR <= addr;
    DATA_IN <= data;
    @(posedge CLK);
    SNES_WR_end <= 1'b0;
    ENABLE <= 1'b1;
    repeat (4) @(posedge CLK);
  endtask

  // Read strobe, then up to 6 cycles for DATA_ENABLE
  task automatic host_read(input logic [9:0] addr, input logic en,
                           output logic [7:0] data, output logic got);
    got = 1'b0;
    data = 8'h00;
    @(posedge CLK);
    ENABLE <= en;
    SNES_RD_start <= 1'b1;
    SNES_ADDR <= addr;
    @(posedge CLK);
    SNES_RD_start <= 1'b0;
    ENABLE <= 1'b1;
    // Sample away from the rising edge
    for (int i = 0; i < 6 && !got; i++) begin
      @(negedge CLK);
      if (DATA_ENABLE) begin
        got = 1'b1;
        data = DATA_OUT;
      end
    end
  endtask

  task automatic check_read(input logic [9:0] addr, input logic [7:0] expected);
    logic [7:0] data;
    logic       got;
    host_read(addr, 1'b1, data, got);
    assert (got) else begin
      $display("ERROR %s: no response to read of offset %h", test_name, addr);
      test_errs++;
    end
    if (got) begin
      assert (data === expected) else begin
        $display("FAILED %s offset %h expected %h actual %h",
                 test_name, addr, expected, data);
        test_errs++;
      end
    end
  endtask

  // Read that must stay unanswered
  task automatic check_silent(input logic [9:0] addr, input logic en);
    logic [7:0] data;
    logic       got;
    host_read(addr, en, data, got);
    assert (!got) else begin
      $display("ERROR %s: unexpected response from offset %h", test_name, addr);
      test_errs++;
    end
  endtask

  // Peek the cache RAM to see where a host offset landed
  task automatic check_cache_index(input logic [8:0] idx, input logic [7:0] expected);
    logic [7:0] actual;
    actual = DUT.cache.mem[idx];
    assert (actual === expected) else begin
      $display("FAILED %s cache index %h expected %h actual %h",
               test_name, idx, expected, actual);
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      $display("Test %s: passed", test_name);
      tests_passed++;
    end else begin
      $display("Test %s: failed with %0d errors", test_name, test_errs);
      tests_failed++;
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_reset();
    start_test("reset_values");
    // GPR bytes live at 0x00..0x1F
    for (int i = 0; i < 32; i++) begin
      check_read(10'(i), 8'h00);
    end
    check_read(10'h030, 8'h00);
    check_read(10'h031, 8'h00);
    check_read(10'h034, 8'h00);
    check_read(10'h036, 8'h00);
    check_read(10'h03C, 8'h00);
    check_read(10'h03E, 8'h00);
    check_read(10'h03F, 8'h00);
    check_read(10'h03B, VERSION);
    finish_test();
  endtask

  task automatic test_gpr();
    logic [15:0] new_val;
    start_test("gpr_write_order");
    for (int r = 0; r < 16; r++) begin
      exp_gpr[r] = rand_bits(16);
      host_write(10'(2 * r), exp_gpr[r][7:0], 1'b1);
      host_write(10'(2 * r + 1), exp_gpr[r][15:8], 1'b1);
    end
    for (int r = 0; r < 16; r++) begin
      check_read(10'(2 * r), exp_gpr[r][7:0]);
      check_read(10'(2 * r + 1), exp_gpr[r][15:8]);
    end
    // Lone low byte waits in the holding register
    new_val = ~exp_gpr[5];
    host_write(10'h00A, new_val[7:0], 1'b1);
    check_read(10'h00A, exp_gpr[5][7:0]);
    check_read(10'h00B, exp_gpr[5][15:8]);
    // High byte commits both
    host_write(10'h00B, new_val[15:8], 1'b1);
    exp_gpr[5] = new_val;
    check_read(10'h00A, exp_gpr[5][7:0]);
    check_read(10'h00B, exp_gpr[5][15:8]);
    finish_test();
  endtask

  task automatic test_masks();
    start_test("register_masks");
    host_write(10'h034, 8'h5A, 1'b1);
    check_read(10'h034, 8'h5A);
    // All ones except GO, low byte keeps bits 6..1
    host_write(10'h030, 8'hDF, 1'b1);
    host_write(10'h031, 8'hFF, 1'b1);
    check_read(10'h030, 8'h5E);
    // High byte keeps bits 7 and 4..0
    check_read(10'h031, 8'h9F);
    host_write(10'h030, 8'h00, 1'b1);
    host_write(10'h031, 8'h00, 1'b1);
    // Constants ignore writes
    host_write(10'h036, 8'hA5, 1'b1);
    host_write(10'h03B, 8'hA5, 1'b1);
    host_write(10'h03C, 8'hA5, 1'b1);
    host_write(10'h03E, 8'hA5, 1'b1);
    host_write(10'h03F, 8'hA5, 1'b1);
    check_read(10'h036, 8'h00);
    check_read(10'h03B, VERSION);
    check_read(10'h03C, 8'h00);
    check_read(10'h03E, 8'h00);
    check_read(10'h03F, 8'h00);
    finish_test();
  endtask

  task automatic test_cache();
    logic [7:0] a;
    start_test("cache_access");
    // exp_cache is indexed by host offset minus 0x100
    for (int i = 0; i < 512; i++) begin
      exp_cache[i] = 8'(rand_bits(8));
      host_write(10'h100 + 10'(i), exp_cache[i], 1'b1);
    end
    for (int i = 0; i < 512; i++) begin
      check_read(10'h100 + 10'(i), exp_cache[i]);
    end
    // Same low byte in both halves, distinct data
    a = 8'(rand_bits(8));
    exp_cache[9'h042] = a;
    exp_cache[9'h142] = ~a;
    host_write(10'h142, a, 1'b1);
    host_write(10'h242, ~a, 1'b1);
    // Host 0x142 lands at index 0x042 and host 0x242 at 0x142
    check_cache_index(9'h042, a);
    check_cache_index(9'h142, ~a);
    check_read(10'h242, ~a);
    check_read(10'h142, a);
    finish_test();
  endtask

  task automatic test_go();
    start_test("go_policy");
    host_write(10'h034, 8'h3C, 1'b1);
    // Set GO, bit 5 of SFR
    host_write(10'h030, 8'h20, 1'b1);
    check_silent(10'h000, 1'b1);
    check_silent(10'h100, 1'b1);
    check_silent(10'h2FF, 1'b1);
    check_silent(10'h034, 1'b1);
    check_read(10'h030, 8'h20);
    check_read(10'h03B, VERSION);
    // Blocked while running
    host_write(10'h034, 8'h99, 1'b1);
    host_write(10'h030, 8'h00, 1'b1);
    check_read(10'h034, 8'h3C);
    check_read(10'h100, exp_cache[0]);
    check_read(10'h2FF, exp_cache[511]);
    check_read(10'h000, exp_gpr[0][7:0]);
    finish_test();
  endtask

  task automatic test_enable();
    start_test("enable_gating");
    check_silent(10'h034, 1'b0);
    check_silent(10'h03B, 1'b0);
    check_silent(10'h100, 1'b0);
    host_write(10'h034, 8'h77, 1'b0);
    host_write(10'h000, 8'h77, 1'b0);
    host_write(10'h001, 8'h77, 1'b0);
    host_write(10'h105, 8'h77, 1'b0);
    // Nothing changed
    check_read(10'h034, 8'h3C);
    check_read(10'h000, exp_gpr[0][7:0]);
    check_read(10'h001, exp_gpr[0][15:8]);
    check_read(10'h105, exp_cache[5]);
    finish_test();
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    RST = 1'b1;
    ENABLE = 1'b0;
    SNES_RD_start = 1'b0;
    SNES_WR_end = 1'b0;
    SNES_ADDR = '0;
    DATA_IN = '0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
    ENABLE <= 1'b1;
    test_reset();
    test_gpr();
    test_masks();
    test_cache();
    test_go();
    test_enable();
    $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("ERROR watchdog: tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== verification/gsu_checker.sv ====
`timescale 1ns/1ns
module gsu_checker (
  input logic CLK,
  input logic RST,
  input logic ENABLE,
  input logic SNES_RD_start,
  input logic SNES_WR_end,
  input logic DATA_ENABLE
);

  // ----------------------------------------
  // Qualified host strobes
  // ----------------------------------------
  logic strobe;
  logic rd_strobe;

  assign strobe = ENABLE & (SNES_RD_start | SNES_WR_end);
  assign rd_strobe = ENABLE & SNES_RD_start;

  // Quiet output during reset and one cycle after
  rst_quiet: assert property (@(posedge CLK)
    ($past(RST) || $past(RST, 2)) |-> !DATA_ENABLE)
    else $error("DATA_ENABLE high during or just after reset");

  // Response is a single-cycle pulse
  one_cycle_rsp: assert property (@(posedge CLK) disable iff (RST)
    DATA_ENABLE |=> !DATA_ENABLE)
    else $error("DATA_ENABLE held high for two cycles");

  // Register reads answer after 3 cycles, cache reads after 4
  rsp_latency: assert property (@(posedge CLK) disable iff (RST)
    DATA_ENABLE |-> ($past(rd_strobe, 3) || $past(rd_strobe, 4)))
    else $error("Read response without a read strobe 3 or 4 cycles before");

  // No back-pressure, so the host keeps strobes apart
  strobe_spacing: assert property (@(posedge CLK) disable iff (RST)
    strobe |-> !($past(strobe) || $past(strobe, 2) || $past(strobe, 3)))
    else $error("Host strobes closer than 4 cycles");

endmodule

// ==== design/gsu.sv ====
`timescale 1ns/1ns
module gsu
  import gsu_map_pkg::*, gsu_bus_pkg::*;
#(
  parameter logic [7:0] VERSION = 8'd4
) (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   ENABLE,
  input  logic                   SNES_RD_start,
  input  logic                   SNES_WR_end,
  input  logic [HOST_ADDR_W-1:0] SNES_ADDR,
  input  logic [7:0]             DATA_IN,
  output logic                   DATA_ENABLE,
  output logic [7:0]             DATA_OUT
);

  access_t   access;
  logic      go;
  host_rsp_t regs_rsp;
  host_rsp_t cache_rsp;

  // ----------------------------------------
  // Host strobe decode
  // ----------------------------------------
  mmio_decode decode (
    .CLK      (CLK),
    .RST      (RST),
    .enable   (ENABLE),
    .rd_start (SNES_RD_start),
    .wr_end   (SNES_WR_end),
    .addr     (SNES_ADDR),
    .wdata    (DATA_IN),
    .go       (go),
    .access   (access)
  );

  // Registers answer one cycle ahead of cache
  gsu_regs #(.VERSION(VERSION)) regs (
    .CLK    (CLK),
    .RST    (RST),
    .access (access),
    .go     (go),
    .rsp    (regs_rsp)
  );

  gsu_cache cache (
    .CLK    (CLK),
    .RST    (RST),
    .access (access),
    .rsp    (cache_rsp)
  );

  // Responses never overlap, idle data is zero
  assign DATA_ENABLE = regs_rsp.valid | cache_rsp.valid;
  assign DATA_OUT = regs_rsp.data | cache_rsp.data;

endmodule

// ==== mmio/gsu_cache.sv ====
`timescale 1ns/1ns
module gsu_cache
  import gsu_map_pkg::*, gsu_bus_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  access_t   access,
  output host_rsp_t rsp
);

  // ----------------------------------------
  // Cache RAM, single port
  // ----------------------------------------
  logic [7:0] mem [CACHE_DEPTH];
  // Synchronous read data
  logic [7:0] ram_q;
  logic       rd_pend;
  logic       cache_hit;

  assign cache_hit = (access.region == REGION_CACHE);

  always_ff @(posedge CLK) begin
    if (cache_hit && access.wr) begin
      mem[access.cache_idx] <= access.data;
    end
    // Read latches index into RAM output
    if (cache_hit && access.rd) begin
      ram_q <= mem[access.cache_idx];
    end
  end

  // ----------------------------------------
  // Response, one cycle behind the RAM
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      rd_pend <= 1'b0;
      rsp.valid <= 1'b0;
      rsp.data <= 8'h00;
    end else begin
      rd_pend <= cache_hit & access.rd;
      rsp.valid <= rd_pend;
      // Zero when idle so the top can OR
      rsp.data <= rd_pend ? ram_q : 8'h00;
    end
  end

endmodule

// ==== mmio/gsu_regs.sv ====
`timescale 1ns/1ns
module gsu_regs
  import gsu_map_pkg::*, gsu_bus_pkg::*;
#(
  parameter logic [7:0] VERSION = 8'd4
) (
  input  logic      CLK,
  input  logic      RST,
  input  access_t   access,
  output logic      go,
  output host_rsp_t rsp
);

  // ----------------------------------------
  // Register state
  // ----------------------------------------
  logic [15:0] gpr [GPR_COUNT];
  // Low byte waits here for the high byte
  logic [7:0]  gpr_lo_hold;
  logic [15:0] sfr;
  // Program bank
  logic [7:0]  pbr;

  logic        reg_hit;
  logic        reg_wr;
  logic        reg_rd;
  logic [7:0]  rd_byte;

  // GPR and special registers are ours
  assign reg_hit = (access.region == REGION_GPR) || (access.region == REGION_SPECIAL);
  assign reg_wr = access.wr & reg_hit;
  assign reg_rd = access.rd & reg_hit;

  // Run flag back to decode
  assign go = sfr[SFR_GO_BIT];

  // ----------------------------------------
  // Host writes
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      for (int i = 0; i < GPR_COUNT; i++) begin
        gpr[i] <= '0;
      end
      gpr_lo_hold <= '0;
      sfr <= '0;
      pbr <= '0;
    end else if (reg_wr) begin
      if (access.region == REGION_GPR) begin
        // Commit whole word on high byte
        if (access.byte_hi) begin
          gpr[access.gpr] <= {access.data, gpr_lo_hold};
        end else begin
          gpr_lo_hold <= access.data;
        end
      end else begin
        case (access.special)
          // Masked flag update, low byte
          SPC_SFR_LO: begin
            sfr[7:0] <= (sfr[7:0] & ~SFR_WMASK_LO) | (access.data & SFR_WMASK_LO);
          end
          // Masked flag update, high byte
          SPC_SFR_HI: begin
            sfr[15:8] <= (sfr[15:8] & ~SFR_WMASK_HI) | (access.data & SFR_WMASK_HI);
          end
          SPC_PBR: begin
            pbr <= access.data;
          end
          // ROMBR VCR RAMBR CBR are read only
          default: begin
          end
        endcase
      end
    end
  end

  // ----------------------------------------
  // Read mux
  // ----------------------------------------
  always_comb begin
    rd_byte = 8'h00;
    if (access.region == REGION_GPR) begin
      rd_byte = access.byte_hi ? gpr[access.gpr][15:8] : gpr[access.gpr][7:0];
    end else begin
      case (access.special)
        SPC_SFR_LO: rd_byte = sfr[7:0];
        SPC_SFR_HI: rd_byte = sfr[15:8];
        SPC_PBR:    rd_byte = pbr;
        // Version constant
        SPC_VCR:    rd_byte = VERSION;
        // Bank and cache base stay zero
        default:    rd_byte = 8'h00;
      endcase
    end
  end

  // One cycle response, data zero when idle
  always_ff @(posedge CLK) begin
    if (RST) begin
      rsp.valid <= 1'b0;
      rsp.data <= 8'h00;
    end else begin
      rsp.valid <= reg_rd;
      rsp.data <= reg_rd ? rd_byte : 8'h00;
    end
  end

endmodule

// ==== mmio/mmio_decode.sv ====
`timescale 1ns/1ns
module mmio_decode
  import gsu_map_pkg::*, gsu_bus_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   enable,
  input  logic                   rd_start,
  input  logic                   wr_end,
  input  logic [HOST_ADDR_W-1:0] addr,
  input  logic [7:0]             wdata,
  input  logic                   go,
  output access_t                access
);

  host_req_t req;
  access_t   acc_next;
  logic      go_allowed;

  // ----------------------------------------
  // Stage 1, capture host request
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    req.addr <= addr;
    req.data <= wdata;
    if (RST) begin
      req.rd <= 1'b0;
      req.wr <= 1'b0;
    end else begin
      // Strobes only count with chip enable
      req.rd <= rd_start & enable;
      req.wr <= wr_end & enable;
    end
  end

  // ----------------------------------------
  // Stage 2, classify by region
  // ----------------------------------------
  always_comb begin
    acc_next.rd = req.rd;
    acc_next.wr = req.wr;
    acc_next.region = REGION_NONE;
    acc_next.special = SPC_SFR_LO;
    // Even offset low byte, odd offset high byte
    acc_next.gpr = req.addr[4:1];
    acc_next.byte_hi = req.addr[0];
    // Cache index flips address bit 8
    acc_next.cache_idx = {~req.addr[8], req.addr[7:0]};
    acc_next.data = req.data;

    if (req.addr[HOST_ADDR_W-1:8] != '0) begin
      acc_next.region = REGION_CACHE;
    end else if (req.addr[7:1] < 7'(GPR_COUNT)) begin
      acc_next.region = REGION_GPR;
    end else begin
      acc_next.region = REGION_SPECIAL;
      case (req.addr[7:0])
        ADDR_SFR:         acc_next.special = SPC_SFR_LO;
        ADDR_SFR + 8'd1:  acc_next.special = SPC_SFR_HI;
        ADDR_PBR:         acc_next.special = SPC_PBR;
        ADDR_ROMBR:       acc_next.special = SPC_ROMBR;
        ADDR_VCR:         acc_next.special = SPC_VCR;
        ADDR_RAMBR:       acc_next.special = SPC_RAMBR;
        ADDR_CBR:         acc_next.special = SPC_CBR_LO;
        ADDR_CBR + 8'd1:  acc_next.special = SPC_CBR_HI;
        // Hole in the map
        default:          acc_next.region = REGION_NONE;
      endcase
    end

    // While running only SFR is open, plus VCR for reads
    go_allowed = (acc_next.region == REGION_SPECIAL) &&
                 ((acc_next.special inside {SPC_SFR_LO, SPC_SFR_HI}) ||
                  (acc_next.special == SPC_VCR && req.rd));
    if (go && !go_allowed) begin
      acc_next.region = REGION_NONE;
    end
  end

  always_ff @(posedge CLK) begin
    access <= acc_next;
    if (RST) begin
      access.rd <= 1'b0;
      access.wr <= 1'b0;
      access.region <= REGION_NONE;
    end
  end

endmodule

// ==== common/gsu_bus_pkg.sv ====
package gsu_bus_pkg;

  import gsu_map_pkg::*;

  // Qualified host strobe with its address and data
  typedef struct packed {
    logic                   rd;
    logic                   wr;
    logic [HOST_ADDR_W-1:0] addr;
    logic [7:0]             data;
  } host_req_t;

  // Classified access, after GO policy
  typedef struct packed {
    logic                         rd;
    logic                         wr;
    region_e                      region;
    special_e                     special;
    logic [$clog2(GPR_COUNT)-1:0] gpr;
    logic                         byte_hi;
    logic [CACHE_ADDR_W-1:0]      cache_idx;
    logic [7:0]                   data;
  } access_t;

  // Read response toward the host
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } host_rsp_t;

endpackage

// ==== common/gsu_map_pkg.sv ====
package gsu_map_pkg;

  // ----------------------------------------
  // Window geometry
  // ----------------------------------------
  // Host register window, byte addressed
  localparam int HOST_ADDR_W = 10;
  // General purpose register file
  localparam int GPR_COUNT = 16;
  // Instruction cache, one byte per entry
  localparam int CACHE_DEPTH = 512;
  localparam int CACHE_ADDR_W = 9;

  // ----------------------------------------
  // Special register offsets
  // ----------------------------------------
  // Status/flag register, two bytes
  localparam logic [7:0] ADDR_SFR = 8'h30;
  localparam logic [7:0] ADDR_PBR = 8'h34;
  localparam logic [7:0] ADDR_ROMBR = 8'h36;
  localparam logic [7:0] ADDR_VCR = 8'h3B;
  localparam logic [7:0] ADDR_RAMBR = 8'h3C;
  // Cache base register, two bytes
  localparam logic [7:0] ADDR_CBR = 8'h3E;

  // SFR run flag
  localparam int SFR_GO_BIT = 5;
  // Z CY S OV GO R in the low byte
  localparam logic [7:0] SFR_WMASK_LO = 8'b0111_1110;
  // IRQ plus B IH IL ALT2 ALT1 in the high byte
  localparam logic [7:0] SFR_WMASK_HI = 8'b1001_1111;

  // Target of a decoded host access
  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_GPR,
    REGION_SPECIAL,
    REGION_CACHE
  } region_e;

  // Special register selector
  typedef enum logic [2:0] {
    SPC_SFR_LO,
    SPC_SFR_HI,
    SPC_PBR,
    SPC_ROMBR,
    SPC_VCR,
    SPC_RAMBR,
    SPC_CBR_LO,
    SPC_CBR_HI
  } special_e;

endpackage
